// ==== verilog/rv_isa_pkg.sv ====
// RV32I instruction encoding for the supported subset
package rv_isa_pkg;

    // Field widths
    localparam int opcode_bits = 7;
    localparam int funct3_bits = 3;
    localparam int funct7_bits = 7;

    // Field positions, low bit of each field
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int funct7_lsb = 25;

    // Major opcodes
    localparam logic [opcode_bits-1:0] op_rtype  = 7'b0110011; // Register-register ALU
    localparam logic [opcode_bits-1:0] op_itype  = 7'b0010011; // Register-immediate ALU
    localparam logic [opcode_bits-1:0] op_load   = 7'b0000011; // lw
    localparam logic [opcode_bits-1:0] op_store  = 7'b0100011; // sw
    localparam logic [opcode_bits-1:0] op_branch = 7'b1100011; // beq
    localparam logic [opcode_bits-1:0] op_lui    = 7'b0110111;
    localparam logic [opcode_bits-1:0] op_auipc  = 7'b0010111;

    // funct3 values of the ALU instructions
    localparam logic [funct3_bits-1:0] f3_add_sub = 3'b000; // add, sub, addi
    localparam logic [funct3_bits-1:0] f3_sll     = 3'b001;
    localparam logic [funct3_bits-1:0] f3_slt     = 3'b010; // Signed compare
    localparam logic [funct3_bits-1:0] f3_xor     = 3'b100;
    localparam logic [funct3_bits-1:0] f3_srl_sra = 3'b101; // funct7 picks the variant
    localparam logic [funct3_bits-1:0] f3_or      = 3'b110;
    localparam logic [funct3_bits-1:0] f3_and     = 3'b111;

    // funct7 of sub and sra, also imm[11:5] of srai
    localparam logic [funct7_bits-1:0] funct7_alt = 7'b0100000;

endpackage

// ==== verilog/rv_core_pkg.sv ====
// Core-internal widths, reset vector and control encodings
package rv_core_pkg;

    localparam int xlen          = 32; // Data path width
    localparam int reg_addr_bits = 5;  // 32 architectural registers
    localparam int mem_addr_bits = 10; // Word address, 1024 words per memory

    localparam logic [xlen-1:0] reset_pc = '0; // First fetch at address zero

    // How much of funct3/funct7 decides the ALU operation
    typedef enum logic [1:0] {
        class_add,       // Loads, stores, lui, auipc
        class_sub,       // beq compare
        class_funct,     // R-type, funct7 may select sub/sra
        class_funct_imm  // I-type, funct7 only selects sra
    } alu_class_e;

    // Concrete ALU operations
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt, // Signed set-less-than
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    // First ALU operand source
    typedef enum logic [1:0] {
        src_a_pc,   // auipc
        src_a_zero, // lui
        src_a_rs1   // Everything else
    } src_a_e;

endpackage

// ==== verilog/program_counter.sv ====
`timescale 1ns/1ps

// Program counter with sequential and branch update
module program_counter import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            take_branch, // beq taken this cycle
    input  logic [xlen-1:0] offset,      // B-type immediate
    output logic [xlen-1:0] pc
);

    logic [xlen-1:0] pc_next;

    // Next PC, sequential or PC-relative target
    always_comb begin
        if (take_branch) begin
            pc_next = pc + offset;
        end else begin
            pc_next = pc + xlen'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc; // Hold the reset vector
        end else begin
            pc <= pc_next;
        end
    end

    // Fetch is word-based, so the PC must never leave a word boundary
    pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00
    );

endmodule

// ==== verilog/main_controller.sv ====
`timescale 1ns/1ps

// Opcode decoder for the single-cycle datapath
module main_controller import rv_isa_pkg::*, rv_core_pkg::*; (
    input  logic                   rst_n,
    input  logic [opcode_bits-1:0] opcode,
    output logic                   branch,      // beq
    output logic                   reg_write,   // Write rd at the clock edge
    output logic                   mem_read,    // Data memory read strobe
    output logic                   mem_write,   // Data memory write strobe
    output logic                   mem_to_reg,  // Writeback from data memory
    output logic                   alu_src_imm, // Second operand is the immediate
    output src_a_e                 src_a,       // First operand select
    output alu_class_e             alu_class    // ALU decode class
);

    always_comb begin
        // Defaults give a harmless no-op
        branch      = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_to_reg  = 1'b0;
        alu_src_imm = 1'b0;
        src_a       = src_a_rs1;
        alu_class   = class_add;

        case (opcode)
            op_rtype: begin
                reg_write = 1'b1;
                alu_class = class_funct; // funct3 and funct7 decide
            end
            op_itype: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_class   = class_funct_imm;
            end
            op_load: begin
                reg_write   = 1'b1;
                mem_read    = 1'b1;
                mem_to_reg  = 1'b1;
                alu_src_imm = 1'b1; // Address is rs1 + imm
            end
            op_store: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1; // Address is rs1 + imm
            end
            op_branch: begin
                branch    = 1'b1;
                alu_class = class_sub; // Zero flag means equal
            end
            op_lui: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                src_a       = src_a_zero; // 0 + upper immediate
            end
            op_auipc: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                src_a       = src_a_pc;   // pc + upper immediate
            end
            default: ; // Unknown opcode leaves all strobes low
        endcase

        // No architectural effect while in reset
        if (!rst_n) begin
            reg_write = 1'b0;
            mem_read  = 1'b0;
            mem_write = 1'b0;
        end
    end

endmodule

// ==== verilog/alu_controller.sv ====
`timescale 1ns/1ps

// Turns decode class and funct fields into an ALU operation
module alu_controller import rv_isa_pkg::*, rv_core_pkg::*; (
    input  alu_class_e             alu_class,
    input  logic [funct3_bits-1:0] funct3,
    input  logic [funct7_bits-1:0] funct7,
    output alu_op_e                alu_op
);

    logic funct7_set; // funct7 carries the alternate encoding

    assign funct7_set = (funct7 == funct7_alt);

    always_comb begin
        case (alu_class)
            class_add: alu_op = alu_add; // Address and upper immediate sums
            class_sub: alu_op = alu_sub; // beq compare
            default: begin
                case (funct3)
                    // addi has no subtract form, so only R-type looks at funct7
                    f3_add_sub: begin
                        if (alu_class == class_funct && funct7_set) begin
                            alu_op = alu_sub;
                        end else begin
                            alu_op = alu_add;
                        end
                    end
                    f3_sll: alu_op = alu_sll;
                    f3_slt: alu_op = alu_slt;
                    f3_xor: alu_op = alu_xor;
                    f3_srl_sra: alu_op = funct7_set ? alu_sra : alu_srl; // srai too
                    f3_or:  alu_op = alu_or;
                    f3_and: alu_op = alu_and;
                    default: alu_op = alu_add; // sltu, sltiu not supported
                endcase
            end
        endcase
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

// Integer ALU for the RV32I subset
module alu import rv_core_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_e         alu_op,
    output logic [xlen-1:0] result,
    output logic            zero    // result == 0, used by beq
);

    logic [4:0] shamt; // Shift amount, low five bits of b

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_slt: begin
                // Signed compare, result is 0 or 1
                if ($signed(a) < $signed(b)) begin
                    result = xlen'(1);
                end else begin
                    result = '0;
                end
            end
            alu_sll: result = a << shamt;
            alu_srl: result = a >> shamt;                  // Zero fill
            alu_sra: result = unsigned'($signed(a) >>> shamt); // Sign fill
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== verilog/register_bank.sv ====
`timescale 1ns/1ps

// 32 x 32-bit integer register file
module register_bank import rv_core_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [reg_addr_bits-1:0] rs1_addr,
    input  logic [reg_addr_bits-1:0] rs2_addr,
    input  logic [reg_addr_bits-1:0] rd_addr,
    input  logic [xlen-1:0]          rd_data,
    input  logic                     write_enable,
    output logic [xlen-1:0]          rs1_data,
    output logic [xlen-1:0]          rs2_data
);

    localparam int num_regs = 2 ** reg_addr_bits;

    logic [xlen-1:0] regs [num_regs];

    // Write at the clock edge, x0 is never written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // Combinational reads within the same cycle
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // x0 stays zero on both ports, whatever was written to it
    x0_is_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((rs1_addr != '0) || (rs1_data == '0)) &&
        ((rs2_addr != '0) || (rs2_data == '0))
    );

endmodule

// ==== verilog/imm_gen.sv ====
`timescale 1ns/1ps

// Immediate extraction and sign extension
module imm_gen import rv_isa_pkg::*, rv_core_pkg::*; (
    input  logic [xlen-1:0] instruction,
    output logic [xlen-1:0] imm
);

    logic [opcode_bits-1:0] opcode;
    logic                   sign;   // Immediate sign, always bit 31

    assign opcode = instruction[opcode_bits-1:0];
    assign sign   = instruction[31];

    always_comb begin
        case (opcode)
            // I format, addi and friends plus lw
            op_itype, op_load: imm = {{20{sign}}, instruction[31:20]};
            // S format, offset split around rs2
            op_store: imm = {{20{sign}}, instruction[31:25], instruction[11:7]};
            op_branch: begin
                // B format, bit 0 is always zero
                imm = {{19{sign}}, instruction[31], instruction[7],
                       instruction[30:25], instruction[11:8], 1'b0};
            end
            op_lui, op_auipc: imm = {instruction[31:12], 12'b0}; // U format
            default: imm = '0; // R-type carries no immediate
        endcase
    end

endmodule

// ==== verilog/core.sv ====
`timescale 1ns/1ps

// Single-cycle RV32I subset core, memories outside
module core import rv_isa_pkg::*, rv_core_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    // Instruction memory, answers within the cycle
    output logic [mem_addr_bits-1:0] imem_addr,  // Word address
    input  logic [xlen-1:0]          imem_data,
    // Data memory, answers within the cycle
    output logic [mem_addr_bits-1:0] dmem_addr,  // Word address
    output logic [xlen-1:0]          dmem_wdata,
    input  logic [xlen-1:0]          dmem_rdata,
    output logic                     dmem_we,    // Write at the rising edge
    output logic                     dmem_re
);

    logic [xlen-1:0]          pc;
    logic [opcode_bits-1:0]   opcode;
    logic [reg_addr_bits-1:0] rd_addr;
    logic [reg_addr_bits-1:0] rs1_addr;
    logic [reg_addr_bits-1:0] rs2_addr;
    logic [funct3_bits-1:0]   funct3;
    logic [funct7_bits-1:0]   funct7;

    logic       branch, reg_write, mem_read, mem_write, mem_to_reg, alu_src_imm;
    src_a_e     src_a;
    alu_class_e alu_class;
    alu_op_e    alu_op;

    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_data, rs2_data;
    logic [xlen-1:0] alu_a, alu_b, alu_result;
    logic            alu_zero;
    logic [xlen-1:0] wb_data;
    logic            take_branch;

    // Instruction fields
    assign opcode   = imem_data[opcode_bits-1:0];
    assign rd_addr  = imem_data[rd_lsb +: reg_addr_bits];
    assign rs1_addr = imem_data[rs1_lsb +: reg_addr_bits];
    assign rs2_addr = imem_data[rs2_lsb +: reg_addr_bits];
    assign funct3   = imem_data[funct3_lsb +: funct3_bits];
    assign funct7   = imem_data[funct7_lsb +: funct7_bits];

    assign imem_addr = pc[mem_addr_bits+1:2]; // Byte PC to word index

    program_counter u_pc (
        .clk, .rst_n, .take_branch, .offset(imm), .pc
    );

    main_controller u_main_ctrl (
        .rst_n, .opcode, .branch, .reg_write, .mem_read, .mem_write,
        .mem_to_reg, .alu_src_imm, .src_a, .alu_class
    );

    alu_controller u_alu_ctrl (.alu_class, .funct3, .funct7, .alu_op);

    imm_gen u_imm_gen (.instruction(imem_data), .imm);

    register_bank u_regs (
        .clk, .rst_n, .rs1_addr, .rs2_addr, .rd_addr,
        .rd_data(wb_data), .write_enable(reg_write), .rs1_data, .rs2_data
    );

    // First operand, pc for auipc and zero for lui
    always_comb begin
        case (src_a)
            src_a_pc:   alu_a = pc;
            src_a_zero: alu_a = '0;
            default:    alu_a = rs1_data;
        endcase
    end

    assign alu_b = alu_src_imm ? imm : rs2_data; // Second operand

    alu u_alu (.a(alu_a), .b(alu_b), .alu_op, .result(alu_result), .zero(alu_zero));

    assign take_branch = branch & alu_zero; // beq taken when rs1 == rs2

    // Data side, address from the ALU sum
    assign dmem_addr  = alu_result[mem_addr_bits+1:2];
    assign dmem_wdata = rs2_data;
    assign dmem_we    = mem_write;
    assign dmem_re    = mem_read;

    assign wb_data = mem_to_reg ? dmem_rdata : alu_result; // Writeback select

endmodule

// ==== sim/core_tb.sv ====
`timescale 1ns/1ps

// Core testbench with instruction ROM and data RAM models
module core_tb import rv_core_pkg::*; ();

    localparam int mem_words = 2 ** mem_addr_bits;
    localparam int clk_half  = 20; // 40 ns period

    localparam logic [6:0] load_opcode = 7'b0000011; // lw major opcode

    logic                     clk;
    logic                     rst_n;
    logic [mem_addr_bits-1:0] imem_addr;
    logic [xlen-1:0]          imem_data;
    logic [mem_addr_bits-1:0] dmem_addr;
    logic [xlen-1:0]          dmem_wdata;
    logic [xlen-1:0]          dmem_rdata;
    logic                     dmem_we;
    logic                     dmem_re;

    logic [xlen-1:0] rom  [mem_words]; // Program
    logic [xlen-1:0] dram [mem_words]; // Data

    logic [31:0] exp_addr [$]; // Expected stores in program order
    logic [31:0] exp_data [$];
    int          num_instrs;
    int          last_instr;       // Word address of the closing self-loop
    int          stores_seen;
    logic        loaded;

    core u_core (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
        .dmem_we(dmem_we), .dmem_re(dmem_re)
    );

    always #clk_half clk = ~clk;

    // Both memories answer within the cycle
    assign imem_data  = rom[imem_addr];
    assign dmem_rdata = dram[dmem_addr];

    always @(posedge clk) begin
        if (dmem_we) begin
            dram[dmem_addr] <= dmem_wdata; // Store lands at the rising edge
        end
    end

    task automatic fail_and_stop();
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    // Compare one value and stop on a mismatch
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            fail_and_stop();
        end
    endtask

    // Only a fetched lw raises the read strobe
    task automatic check_load_strobe();
        check_value(dmem_re, imem_data[6:0] == load_opcode, "load strobe");
    endtask

    // Reads tagged I program words, D data words and S expected stores
    task automatic load_tests();
        int          fd;
        int          code;
        string       line;
        byte         tag;
        logic [31:0] addr;
        logic [31:0] value;

        fd = $fopen("sim/core_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file sim/core_tests.txt");
            fail_and_stop();
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code == 0 || line.len() < 2 || line[0] == "#") begin
                    continue; // Blank or comment line
                end
                code = $sscanf(line, "%c %h %h", tag, addr, value);
                if (code != 3 || addr >= mem_words) begin
                    $display("Malformed line in the test file: %s", line);
                    fail_and_stop();
                end
                case (tag)
                    "I": begin
                        rom[addr]  = value;
                        num_instrs = num_instrs + 1;
                        last_instr = addr; // Last word is the self-loop
                    end
                    "D": dram[addr] = value;
                    "S": begin
                        exp_addr.push_back(addr);
                        exp_data.push_back(value);
                    end
                    default: begin
                        $display("Unknown tag in the test file: %s", line);
                        fail_and_stop();
                    end
                endcase
            end
            $fclose(fd);
        end
    endtask

    // Each store against the next expected entry
    always @(negedge clk) begin
        if (loaded && dmem_we === 1'b1) begin
            if (stores_seen >= exp_addr.size()) begin
                $display("Unexpected store to word %h after the last expected one", dmem_addr);
                fail_and_stop();
            end else begin
                check_value(dmem_addr, exp_addr[stores_seen],
                            $sformatf("store %0d address", stores_seen));
                check_value(dmem_wdata, exp_data[stores_seen],
                            $sformatf("store %0d data", stores_seen));
                stores_seen = stores_seen + 1;
            end
        end
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        num_instrs  = 0;
        last_instr  = 0;
        stores_seen = 0;
        loaded      = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            rom[i]  = (i << 20) | 32'h13;  // addi x0, x0, addr as filler
            dram[i] = 32'hA5A50000 ^ i;
        end
        load_tests();
        loaded = 1'b1;

        repeat (5) begin
            @(negedge clk);
            check_value(imem_addr, 0, "fetch address in reset");
            check_value(dmem_we, 0, "store strobe in reset");
            check_value(dmem_re, 0, "load strobe in reset");
        end
        rst_n = 1'b1; // Released on a falling edge
        @(negedge clk);
        check_value(imem_addr, 1, "fetch address after the first instruction");
        check_load_strobe();

        while (stores_seen < exp_addr.size()) begin
            @(negedge clk);
            check_load_strobe();
        end
        repeat (4) @(negedge clk); // Spin in the beq loop
        check_value(imem_addr, last_instr, "self-loop fetch address");
        $display("Simulation completed successfully");
        $finish;
    end

    // Watchdog sized from the program length
    initial begin
        wait (loaded);
        repeat (4 * num_instrs + 100) @(posedge clk);
        $display("Timeout, only %0d of %0d expected stores were seen",
                 stores_seen, exp_addr.size());
        fail_and_stop();
    end

endmodule

// ==== sim/core_tests.txt ====
# Columns: tag, word address (hex), value (hex), then an optional note
# I = program word, D = initial data word, S = expected store in program order
D 080 12345678 # Read back by lw
I 000 00C00093 # addi x1, x0, 12
I 001 FFB00113 # addi x2, x0, -5
I 002 002081B3 # add  x3, x1, x2
I 003 10302023 # sw   x3, 0x100(x0)
S 040 00000007
I 004 40110233 # sub  x4, x2, x1
I 005 10402223 # sw   x4, 0x104(x0)
S 041 FFFFFFEF
I 006 0020F2B3 # and  x5, x1, x2
I 007 10502423 # sw   x5, 0x108(x0)
S 042 00000008
I 008 0020E2B3 # or   x5, x1, x2
I 009 10502623 # sw   x5, 0x10c(x0)
S 043 FFFFFFFF
I 00A 0020C2B3 # xor  x5, x1, x2
I 00B 10502823 # sw   x5, 0x110(x0)
S 044 FFFFFFF7
I 00C 001122B3 # slt  x5, x2, x1, signed -5 < 12
I 00D 10502A23 # sw   x5, 0x114(x0)
S 045 00000001
I 00E 00111333 # sll  x6, x2, x1
I 00F 10602C23 # sw   x6, 0x118(x0)
S 046 FFFFB000
I 010 00115333 # srl  x6, x2, x1
I 011 10602E23 # sw   x6, 0x11c(x0)
S 047 000FFFFF
I 012 40525333 # sra  x6, x4, x5, -17 >>> 1
I 013 12602023 # sw   x6, 0x120(x0)
S 048 FFFFFFF7
I 014 0F017393 # andi x7, x2, 0x0f0
I 015 12702223 # sw   x7, 0x124(x0)
S 049 000000F0
I 016 F000E393 # ori  x7, x1, -256
I 017 12702423 # sw   x7, 0x128(x0)
S 04A FFFFFF0C
I 018 FFF14393 # xori x7, x2, -1
I 019 12702623 # sw   x7, 0x12c(x0)
S 04B 00000004
I 01A FFC12393 # slti x7, x2, -4
I 01B 12702823 # sw   x7, 0x130(x0)
S 04C 00000001
I 01C 20002403 # lw   x8, 0x200(x0)
I 01D 00140413 # addi x8, x8, 1
I 01E 12802A23 # sw   x8, 0x134(x0)
S 04D 12345679
I 01F 10402483 # lw   x9, 0x104(x0), word stored earlier
I 020 001484B3 # add  x9, x9, x1
I 021 12902C23 # sw   x9, 0x138(x0)
S 04E FFFFFFFB
I 022 00248463 # beq  x9, x2, +8, taken
I 023 12102E23 # sw   x1, 0x13c(x0), skipped
I 024 00208463 # beq  x1, x2, +8, not taken
I 025 14202023 # sw   x2, 0x140(x0)
S 050 FFFFFFFB
I 026 ABCDE537 # lui  x10, 0xabcde
I 027 14A02223 # sw   x10, 0x144(x0)
S 051 ABCDE000
I 028 00001597 # auipc x11, 0x1 at byte 0xa0
I 029 14B02423 # sw   x11, 0x148(x0)
S 052 000010A0
I 02A 06300013 # addi x0, x0, 99
I 02B 14002623 # sw   x0, 0x14c(x0)
S 053 00000000
I 02C 00000063 # beq  x0, x0, 0

// ==== filelist.f ====
verilog/rv_isa_pkg.sv
verilog/rv_core_pkg.sv
verilog/program_counter.sv
verilog/main_controller.sv
verilog/alu_controller.sv
verilog/alu.sv
verilog/register_bank.sv
verilog/imm_gen.sv
verilog/core.sv
sim/core_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_single_cycle

sources:
  - files:
      - verilog/rv_isa_pkg.sv
      - verilog/rv_core_pkg.sv
      - verilog/program_counter.sv
      - verilog/main_controller.sv
      - verilog/alu_controller.sv
      - verilog/alu.sv
      - verilog/register_bank.sv
      - verilog/imm_gen.sv
      - verilog/core.sv
  - target: simulation
    files:
      - sim/core_tb.sv
